// File: verilog/clock_set_defs.svh
`ifndef CLOCK_SET_DEFS_SVH
`define CLOCK_SET_DEFS_SVH

// edges a button pair must be held before the counter reaches the act point
`define HOLD_CYCLES 3

// year(4) month(2) day(2) hour(2) minute(2) second(2)
`define NUM_DIGITS 14

// cursor starts on the year thousands digit
`define CURSOR_START 13

// 2023-01-01 00:00:00 in packed BCD
`define RESET_DATE 56'h2023_01_01_00_00_00

`endif

// File: verilog/clock_set_pkg.sv
package clock_set_pkg;

`include "clock_set_defs.svh"

    // raw button levels
    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
    } buttons_t;

    // field view of the record, most significant first
    typedef struct packed {
        logic [15:0] year;   // four bcd digits
        logic [7:0]  month;
        logic [7:0]  day;
        logic [7:0]  hour;
        logic [7:0]  minute;
        logic [7:0]  second;
    } time_fields_t;

    // same 56 bits seen as fields or as individual digits
    // digit 0 is seconds units, digit 13 is year thousands
    typedef union packed {
        time_fields_t                        fields;
        logic [`NUM_DIGITS-1:0][3:0]         digits;
    } time_word_u;

    typedef logic [3:0] digit_idx_t;

    // legal span of the digit under the cursor
    typedef struct packed {
        logic [3:0] min;
        logic [3:0] max;
    } digit_range_t;

endpackage

// File: verilog/hold_detect.sv
`include "clock_set_defs.svh"

module hold_detect (
    input  logic clk,
    input  logic start_set,
    input  logic first,
    input  logic second,
    output logic first_pulse,
    output logic second_pulse
);

    // one step past the threshold so the counter can park there
    localparam int CNT_W = $clog2(`HOLD_CYCLES + 2);

    logic [CNT_W-1:0] hold_cnt;
    logic             held;
    logic             fire;

    assign held = first | second;

    always_ff @(posedge clk or posedge start_set) begin
        if (start_set) begin
            hold_cnt <= '0;
        end else if (!held) begin
            hold_cnt <= '0;
        end else if (hold_cnt != CNT_W'(`HOLD_CYCLES + 1)) begin
            hold_cnt <= hold_cnt + 1'b1;   // saturates, no auto repeat
        end
    end

    assign fire         = held && (hold_cnt == CNT_W'(`HOLD_CYCLES));
    assign first_pulse  = fire & first;
    assign second_pulse = fire & ~first & second;

endmodule

// File: verilog/digit_cursor.sv
`include "clock_set_defs.svh"

module digit_cursor (
    input  logic                      clk,
    input  logic                      start_set,
    input  logic                      move_left,
    input  logic                      move_right,
    output clock_set_pkg::digit_idx_t cursor
);

    localparam clock_set_pkg::digit_idx_t LAST_IDX =
        clock_set_pkg::digit_idx_t'(`NUM_DIGITS - 1);

    always_ff @(posedge clk or posedge start_set) begin
        if (start_set) begin
            cursor <= clock_set_pkg::digit_idx_t'(`CURSOR_START);
        end else if (move_left) begin
            // toward the more significant digits
            if (cursor >= LAST_IDX) begin
                cursor <= '0;
            end else begin
                cursor <= cursor + 1'b1;
            end
        end else if (move_right) begin
            if (cursor == '0) begin
                cursor <= LAST_IDX;        // wrap back to year thousands
            end else begin
                cursor <= cursor - 1'b1;
            end
        end
    end

endmodule

// File: verilog/digit_limits.sv
module digit_limits (
    input  clock_set_pkg::time_word_u   record,
    input  clock_set_pkg::digit_idx_t   cursor,
    output clock_set_pkg::digit_range_t range
);

    clock_set_pkg::time_fields_t f;
    logic [6:0] yy_bin;
    logic [6:0] cc_bin;
    logic       leap_year;
    logic       february;
    logic       long_month;

    assign f = record.fields;

    // split year into century and year-of-century for the leap test
    assign yy_bin = {3'b000, f.year[7:4]} * 7'd10 + {3'b000, f.year[3:0]};
    assign cc_bin = {3'b000, f.year[15:12]} * 7'd10 + {3'b000, f.year[11:8]};

    assign leap_year = (yy_bin == 7'd0) ? (cc_bin[1:0] == 2'b00)
                                        : (yy_bin[1:0] == 2'b00);

    assign february = (f.month == 8'h02);

    always_comb begin
        case (f.month)
            8'h01, 8'h03, 8'h05, 8'h07, 8'h08, 8'h10, 8'h12: long_month = 1'b1;
            default: long_month = 1'b0;
        endcase
    end

    always_comb begin
        range.min = 4'd0;
        range.max = 4'd9;
        case (cursor)
            4'd10: begin                                   // year units
                if (f.year[15:4] == 12'h000) begin
                    range.min = 4'd1;                      // no year 0000
                end
            end
            4'd9: range.max = 4'd1;                        // month tens
            4'd8: begin
                if (f.month[7:4] == 4'd1) begin
                    range.max = 4'd2;
                end else begin
                    range.min = 4'd1;
                end
            end
            4'd7: range.max = february ? 4'd2 : 4'd3;      // day tens
            4'd6: begin                                    // day units
                case (f.day[7:4])
                    4'd0: range.min = 4'd1;
                    4'd1: range.max = 4'd9;
                    4'd2: begin
                        if (february) begin
                            range.max = leap_year ? 4'd9 : 4'd8;
                        end
                    end
                    default: range.max = long_month ? 4'd1 : 4'd0;
                endcase
            end
            4'd5: range.max = 4'd2;                        // hour tens
            4'd4: range.max = (f.hour[7:4] == 4'd2) ? 4'd3 : 4'd9;
            4'd3: range.max = 4'd5;                        // minute tens
            4'd1: range.max = 4'd5;                        // second tens
            default: begin
                range.min = 4'd0;
                range.max = 4'd9;
            end
        endcase
    end

endmodule

// File: verilog/time_register.sv
`include "clock_set_defs.svh"

module time_register (
    input  logic                        clk,
    input  logic                        start_set,
    input  logic                        step_up,
    input  logic                        step_down,
    input  clock_set_pkg::digit_idx_t   cursor,
    input  clock_set_pkg::digit_range_t range,
    output clock_set_pkg::time_word_u   record
);

    logic [3:0] cur_digit;
    logic [3:0] next_digit;

    assign cur_digit = record.digits[cursor];

    always_comb begin
        next_digit = cur_digit;
        if (step_up) begin
            if (cur_digit >= range.max) begin
                next_digit = range.min;            // wrap to bottom
            end else begin
                next_digit = cur_digit + 4'd1;
            end
        end else if (step_down) begin
            if (cur_digit <= range.min) begin
                next_digit = range.max;
            end else begin
                next_digit = cur_digit - 4'd1;
            end
        end
    end

    // only the selected digit moves, neighbours stay as they are
    always_ff @(posedge clk or posedge start_set) begin
        if (start_set) begin
            record <= `RESET_DATE;
        end else if (step_up || step_down) begin
            record.digits[cursor] <= next_digit;
        end
    end

endmodule

// File: verilog/weekday_calc.sv
module weekday_calc (
    input  clock_set_pkg::time_word_u record,
    output logic [3:0]                week
);

    clock_set_pkg::time_fields_t f;
    int year_bin;
    int month_bin;
    int day_bin;
    int y_adj;
    int m_adj;
    int total;
    int rem;

    assign f = record.fields;

    always_comb begin
        year_bin  = f.year[15:12] * 1000 + f.year[11:8] * 100
                  + f.year[7:4] * 10 + f.year[3:0];
        month_bin = f.month[7:4] * 10 + f.month[3:0];
        day_bin   = f.day[7:4] * 10 + f.day[3:0];

        // jan and feb count as months 13 and 14 of the year before
        if (month_bin == 1 || month_bin == 2) begin
            m_adj = month_bin + 12;
            y_adj = year_bin - 1;
        end else begin
            m_adj = month_bin;
            y_adj = year_bin;
        end

        total = day_bin + 2 * m_adj + (3 * (m_adj + 1)) / 5
              + y_adj + y_adj / 4 - y_adj / 100 + y_adj / 400 + 1;
        rem   = total % 7;

        if (rem == 0) begin
            week = 4'd7;                           // sunday
        end else begin
            week = 4'(rem);
        end
    end

endmodule

// File: verilog/clock_set_top.sv
module clock_set_top (
    input  logic                        clk,
    input  logic                        start_set,
    input  clock_set_pkg::buttons_t     buttons,
    output clock_set_pkg::time_fields_t now,
    output logic [3:0]                  week
);

    logic                        move_left;
    logic                        move_right;
    logic                        step_up;
    logic                        step_down;
    clock_set_pkg::digit_idx_t   cursor;
    clock_set_pkg::digit_range_t range;
    clock_set_pkg::time_word_u   record;

    hold_detect u_move_hold (          // left beats right
        .clk          (clk),
        .start_set    (start_set),
        .first        (buttons.left),
        .second       (buttons.right),
        .first_pulse  (move_left),
        .second_pulse (move_right)
    );

    hold_detect u_step_hold (          // up beats down
        .clk          (clk),
        .start_set    (start_set),
        .first        (buttons.up),
        .second       (buttons.down),
        .first_pulse  (step_up),
        .second_pulse (step_down)
    );

    digit_cursor u_cursor (
        .clk        (clk),
        .start_set  (start_set),
        .move_left  (move_left),
        .move_right (move_right),
        .cursor     (cursor)
    );

    digit_limits u_limits (
        .record (record),
        .cursor (cursor),
        .range  (range)
    );

    time_register u_time_reg (
        .clk       (clk),
        .start_set (start_set),
        .step_up   (step_up),
        .step_down (step_down),
        .cursor    (cursor),
        .range     (range),
        .record    (record)
    );

    weekday_calc u_weekday (
        .record (record),
        .week   (week)
    );

    assign now = record.fields;

endmodule

// File: verification/clock_set_props.sv
`include "clock_set_defs.svh"

module clock_set_props (
    input logic                      clk,
    input logic                      start_set,
    input logic                      move_left,
    input logic                      move_right,
    input logic                      step_up,
    input logic                      step_down,
    input clock_set_pkg::digit_idx_t cursor,
    input clock_set_pkg::time_word_u record
);

    move_exclusive: assert property (@(posedge clk) disable iff (start_set)
        !(move_left && move_right))
        else $error("left and right move pulses active in the same cycle");

    step_exclusive: assert property (@(posedge clk) disable iff (start_set)
        !(step_up && step_down))
        else $error("up and down step pulses active in the same cycle");

    cursor_in_range: assert property (@(posedge clk) disable iff (start_set)
        cursor < `NUM_DIGITS)
        else $error("cursor %0d points past the last digit", cursor);

    // every digit of the record must stay a legal bcd value
    for (genvar i = 0; i < `NUM_DIGITS; i++) begin : g_digit
        digit_is_bcd: assert property (@(posedge clk) disable iff (start_set)
            record.digits[i] <= 4'd9)
            else $error("record digit %0d holds a non bcd value", i);
    end

endmodule

bind clock_set_top clock_set_props u_props (
    .clk        (clk),
    .start_set  (start_set),
    .move_left  (move_left),
    .move_right (move_right),
    .step_up    (step_up),
    .step_down  (step_down),
    .cursor     (cursor),
    .record     (record)
);

// File: verification/clock_set_tb.sv
`include "clock_set_defs.svh"

module clock_set_tb;

    localparam int     SEED          = 14477;
    localparam int     NUM_EPISODES  = 6000;
    localparam int     CLK_PERIOD    = 20;
    localparam int     DRIVE_DELAY   = 2;
    // an episode is at most 8 held plus 3 released cycles, budgeted as 12
    localparam longint WATCHDOG_TIME = 64'(NUM_EPISODES) * 12 * CLK_PERIOD * 2;

    logic                        clk;
    logic                        start_set;
    clock_set_pkg::buttons_t     buttons;
    clock_set_pkg::time_fields_t now;
    logic [3:0]                  week;

    int         move_cnt;                  // reference hold counters
    int         step_cnt;
    int         ref_cursor;
    logic [3:0] ref_digits [`NUM_DIGITS];  // digit 0 is seconds units
    bit         checking;

    clock_set_top UUT (
        .clk       (clk),
        .start_set (start_set),
        .buttons   (buttons),
        .now       (now),
        .week      (week)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // decimal value of count digits, starting at the most significant one
    function automatic int decimal(input int top, input int count);
        int value;
        value = 0;
        for (int k = 0; k < count; k++) begin
            value = value * 10 + int'(ref_digits[top - k]);
        end
        return value;
    endfunction

    function automatic logic [55:0] packed_record();
        logic [55:0] word;
        word = '0;
        for (int i = 0; i < `NUM_DIGITS; i++) begin
            word[i*4 +: 4] = ref_digits[i];
        end
        return word;
    endfunction

    // gregorian weekday, 1 = monday .. 7 = sunday
    function automatic int weekday_of();
        int y;
        int m;
        int d;
        int total;
        int r;
        y = decimal(13, 4);
        m = decimal(9, 2);
        d = decimal(7, 2);
        if (m == 1 || m == 2) begin
            m = m + 12;                    // counted in the year before
            y = y - 1;
        end
        total = d + 2 * m + (3 * (m + 1)) / 5 + y + y / 4 - y / 100 + y / 400 + 1;
        r = total % 7;
        return (r == 0) ? 7 : r;
    endfunction

    task automatic bounds_for(input int idx, output int lo, output int hi);
        int year;
        int month;
        bit leap;
        bit feb;
        bit long_m;
        year   = decimal(13, 4);
        month  = decimal(9, 2);
        leap   = (year % 400 == 0) || (year % 4 == 0 && year % 100 != 0);
        feb    = (month == 2);
        long_m = month inside {1, 3, 5, 7, 8, 10, 12};
        lo = 0;
        hi = 9;
        case (idx)
            10: begin
                if (decimal(13, 3) == 0) begin
                    lo = 1;                // year 0000 not allowed
                end
            end
            9: hi = 1;
            8: begin
                if (ref_digits[9] == 4'd1) begin
                    hi = 2;
                end else begin
                    lo = 1;
                end
            end
            7: hi = feb ? 2 : 3;
            6: begin
                case (ref_digits[7])
                    4'd0: lo = 1;
                    4'd2: begin
                        if (feb) begin
                            hi = leap ? 9 : 8;
                        end
                    end
                    4'd3: hi = long_m ? 1 : 0;
                    default: hi = 9;
                endcase
            end
            5: hi = 2;
            4: hi = (ref_digits[5] == 4'd2) ? 3 : 9;
            3, 1: hi = 5;                  // minute and second tens
            default: hi = 9;
        endcase
    endtask

    task automatic reset_model();
        logic [55:0] start_word;
        start_word = `RESET_DATE;
        move_cnt   = 0;
        step_cnt   = 0;
        ref_cursor = `CURSOR_START;
        for (int i = 0; i < `NUM_DIGITS; i++) begin
            ref_digits[i] = start_word[i*4 +: 4];
        end
    endtask

    task automatic advance_model(input clock_set_pkg::buttons_t b);
        bit move_fire;
        bit step_fire;
        bit go_left;
        bit go_right;
        bit go_up;
        bit go_down;
        int lo;
        int hi;
        int cur;
        move_fire = (b.left || b.right) && (move_cnt == `HOLD_CYCLES);
        step_fire = (b.up || b.down) && (step_cnt == `HOLD_CYCLES);
        go_left   = move_fire && b.left;
        go_right  = move_fire && !b.left && b.right;
        go_up     = step_fire && b.up;
        go_down   = step_fire && !b.up && b.down;
        if (!(b.left || b.right)) begin
            move_cnt = 0;
        end else if (move_cnt <= `HOLD_CYCLES) begin
            move_cnt = move_cnt + 1;
        end
        if (!(b.up || b.down)) begin
            step_cnt = 0;
        end else if (step_cnt <= `HOLD_CYCLES) begin
            step_cnt = step_cnt + 1;
        end
        // step uses the cursor from before this edge
        if (go_up || go_down) begin
            bounds_for(ref_cursor, lo, hi);
            cur = int'(ref_digits[ref_cursor]);
            if (go_up) begin
                cur = (cur >= hi) ? lo : cur + 1;
            end else begin
                cur = (cur <= lo) ? hi : cur - 1;
            end
            ref_digits[ref_cursor] = 4'(cur);
        end
        if (go_left) begin
            ref_cursor = (ref_cursor == `NUM_DIGITS - 1) ? 0 : ref_cursor + 1;
        end else if (go_right) begin
            ref_cursor = (ref_cursor == 0) ? `NUM_DIGITS - 1 : ref_cursor - 1;
        end
    endtask

    always @(posedge clk or posedge start_set) begin
        if (start_set) begin
            reset_model();
        end else begin
            advance_model(buttons);
        end
    end

    always @(negedge clk) begin
        if (checking) begin
            compare("now", 64'(now), 64'(packed_record()));
            compare("week", 64'(week), 64'(weekday_of()));
        end
    end

    task automatic drive(input clock_set_pkg::buttons_t b, input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #DRIVE_DELAY buttons = b;
        end
    endtask

    task automatic run_episode();
        clock_set_pkg::buttons_t pick;
        int hold_len;
        int gap_len;
        pick     = clock_set_pkg::buttons_t'(4'($urandom % 16));
        hold_len = int'($urandom % 9);
        gap_len  = 1 + int'($urandom % 3);
        drive(pick, hold_len);
        drive('0, gap_len);                // release clears both counters
    endtask

    initial begin
        clk       = 1'b0;
        start_set = 1'b1;
        buttons   = '0;
        checking  = 1'b0;
        void'($urandom(SEED));
        repeat (10) @(posedge clk);
        #DRIVE_DELAY start_set = 1'b0;
        @(negedge clk);
        compare("now", 64'(now), 64'(`RESET_DATE));
        compare("week", 64'(week), 64'(7));       // 2023-01-01 was a sunday
        checking = 1'b1;
        for (int e = 0; e < NUM_EPISODES; e++) begin
            run_episode();
        end
        @(negedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the random episodes did not finish within the time limit");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: sources.f
+incdir+verilog
verilog/clock_set_pkg.sv
verilog/hold_detect.sv
verilog/digit_cursor.sv
verilog/digit_limits.sv
verilog/time_register.sv
verilog/weekday_calc.sv
verilog/clock_set_top.sv
verification/clock_set_props.sv
verification/clock_set_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= clock_set_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Simulation completed successfully

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) verilog/clock_set_defs.svh

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
